// File: periph_cfg_bridge.f
rtl/axi_lite_pkg.sv
rtl/regbus_pkg.sv
rtl/axi_lite_capture.sv
rtl/reg_addr_decode.sv
rtl/fll_cfg_regs.sv
rtl/bootrom_rom.sv
rtl/axi_lite_respond.sv
rtl/periph_cfg_bridge.sv
tb/tb_clock.sv
tb/periph_cfg_bridge_props.sv
tb/periph_cfg_bridge_tb.sv

// File: tb/periph_cfg_trace.txt
# test op addr wdata strb rdata resp, op 1 = write and 0 = read
# test in decimal, the rest in hex, rdata is ignored for writes
1 0 000001000000 00000000 0 f1402573 0
1 0 000001000004 00000000 0 00000597 0
1 0 000001000008 00000000 0 03c58593 0
1 0 00000100000c 00000000 0 00051463 0
1 0 000001000010 00000000 0 0080006f 0
1 0 000001000014 00000000 0 10500073 0
1 0 000001000018 00000000 0 ffdff06f 0
1 0 00000100001c 00000000 0 020002b7 0
1 0 000001000020 00000000 0 00128293 0
1 0 000001000024 00000000 0 0052a023 0
1 0 000001000028 00000000 0 01000337 0
1 0 00000100002c 00000000 0 04030313 0
1 0 000001000030 00000000 0 00030067 0
1 0 000001000034 00000000 0 00000013 0
1 0 000001000038 00000000 0 00000013 0
1 0 00000100003c 00000000 0 b007c0de 0
1 1 000001000000 12345678 f 00000000 2
2 1 000002000000 11223344 6 00000000 0
2 0 000002000000 00000000 0 00223300 0
2 1 000002000004 deadbeef 9 00000000 0
2 0 000002000004 00000000 0 de0000ef 0
2 1 000002000008 cafef00d 3 00000000 0
2 0 000002000008 00000000 0 0000f00d 0
2 1 000002001000 a5a5a5a4 1 00000000 0
2 0 000002001000 00000000 0 000000a4 0
2 1 000002001004 0f0f0f0f c 00000000 0
2 0 000002001004 00000000 0 0f0f0000 0
2 1 000002001008 87654321 2 00000000 0
2 0 000002001008 00000000 0 00004300 0
2 1 000002002000 55aa55aa 8 00000000 0
2 0 000002002000 00000000 0 55000000 0
2 1 000002002004 13579bdf 4 00000000 0
2 0 000002002004 00000000 0 00570000 0
2 1 000002002008 fedcba98 e 00000000 0
2 0 000002002008 00000000 0 fedcba00 0
3 0 00000200000c 00000000 0 00000000 0
3 1 000002000000 00000001 1 00000000 0
3 0 00000200000c 00000000 0 00000001 0
3 1 00000200000c ffffffff f 00000000 2
3 0 00000200000c 00000000 0 00000001 0
3 0 000002000000 00000000 0 00223301 0
3 1 000002000000 00000000 1 00000000 0
3 0 00000200000c 00000000 0 00000000 0
4 0 000003000000 00000000 0 00000000 2
4 1 000003000000 ffffffff f 00000000 2
4 0 000001000040 00000000 0 00000000 2
4 0 000002000010 00000000 0 00000000 2
5 0 000001000000 00000000 0 f1402573 0
5 1 000002001004 ffffffff 1 00000000 0
5 0 000002001004 00000000 0 0f0f00ff 0
6 1 000002002000 000000c3 1 00000000 0
6 0 00000200200c 00000000 0 00000001 0
6 0 000002002000 00000000 0 550000c3 0
6 1 000002002008 11111111 1 00000000 0
6 0 00000100003c 00000000 0 b007c0de 0
6 0 000002002008 00000000 0 fedcba11 0
6 1 000002002004 22222222 2 00000000 0
6 1 000002002004 33333333 8 00000000 0
6 0 000002002004 00000000 0 33572200 0
6 1 00000100000c 00000000 f 00000000 2

// File: tb/periph_cfg_bridge_tb.sv
// Trace-driven testbench for the peripheral configuration bridge
// AXI-Lite master with random back-pressure and an in-order response checker
module periph_cfg_bridge_tb
  import axi_lite_pkg::*;
();

  typedef struct packed {
    logic [7:0]           test;
    logic                 write;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] strb;
    logic [DataWidth-1:0] rdata;
    logic [1:0]           resp;
  } trace_t;

  typedef struct packed {
    trace_t      txn;
    logic [15:0] idx;       // trace entry
    logic [31:0] acc_edge;  // edge of acceptance
  } expect_t;

  logic          clk;
  logic          rst;
  axi_lite_req_t req;
  axi_lite_rsp_t rsp;

  trace_t      trace_q[$];
  expect_t     exp_q[$];
  trace_t      cur;
  logic [15:0] cur_idx;
  logic        accepted;
  logic        latency_mode;
  logic        loaded = 1'b0;
  logic [31:0] lfsr;
  logic [31:0] cyc = '0;
  int          n_pass;
  int          n_fail;
  int          test_fail;

  tb_clock i_clock (.clk_o(clk));

  periph_cfg_bridge uut (
    .clk_i          ( clk ),
    .rst_i          ( rst ),
    .axi_lite_req_i ( req ),
    .axi_lite_rsp_o ( rsp )
  );

  always @(posedge clk) cyc <= cyc + 1;

  // ##########################################################################
  // helpers
  // ##########################################################################
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[6:0], lfsr[0]};
    end
  endtask

  function automatic string test_name(input int t);
    case (t)
      1: return "boot rom access";
      2: return "fll strobed writes";
      3: return "fll lock register";
      4: return "unmapped access";
      5: return "isolated latency";
      default: return "back-pressure traffic";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expv,
                             input logic [31:0] got, input logic [15:0] idx);
    assert (got === expv) begin
      n_pass++;
    end else begin
      n_fail++;
      test_fail++;
      $display("CHECK FAILED %s expected %h got %h (trace entry %0d)", name, expv, got, idx);
    end
  endtask

  task automatic load_trace();
    int                   fd;
    int                   cnt;
    string                line;
    logic [31:0]          t, op, strb, resp;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata, rdata;
    fd = $fopen("tb/periph_cfg_trace.txt", "r");
    if (fd == 0) begin
      n_fail++;
      $display("could not open the trace file");
    end else begin
      while (!$feof(fd)) begin
        cnt = $fgets(line, fd);
        if (cnt > 1 && line.getc(0) != "#") begin
          cnt = $sscanf(line, "%d %h %h %h %h %h %h", t, op, addr, wdata, strb, rdata, resp);
          if (cnt == 7) begin
            trace_q.push_back({t[7:0], op[0], addr, wdata, strb[3:0], rdata, resp[1:0]});
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // readies change here too, so all random draws stay in one process
  task automatic next_cycle();
    logic [7:0] r;
    @(posedge clk);
    #2;
    if (latency_mode) begin
      req.b_ready = 1'b1;
      req.r_ready = 1'b1;
    end else begin
      take_bits(2, r);
      req.b_ready = (r[1:0] != 2'b00);  // ready three cycles in four
      take_bits(2, r);
      req.r_ready = (r[1:0] != 2'b00);
    end
  endtask

  task automatic idle_bus();
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
    req.ar_valid = 1'b0;
  endtask

  task automatic issue(input trace_t e, input logic [15:0] idx);
    logic [7:0] r;
    if (latency_mode) begin
      idle_bus();
      while (exp_q.size() != 0) next_cycle();
      req.b_ready = 1'b1;
      req.r_ready = 1'b1;
    end else begin
      take_bits(2, r);
      while (r[1:0] == 2'b00) begin  // idle gap
        idle_bus();
        next_cycle();
        take_bits(2, r);
      end
    end
    cur          = e;
    cur_idx      = idx;
    accepted     = 1'b0;
    req.aw_valid = e.write;
    req.w_valid  = e.write;
    req.aw_addr  = e.addr;
    req.w_data   = e.wdata;
    req.w_strb   = e.strb;
    req.ar_valid = !e.write;
    req.ar_addr  = e.addr;
    next_cycle();
    while (!accepted) next_cycle();
  endtask

  task automatic retire(input logic is_write);
    expect_t x;
    assert (exp_q.size() != 0) begin
      x = exp_q.pop_front();
      assert (x.txn.write == is_write) else begin
        n_fail++;
        test_fail++;
        $display("response for trace entry %0d came back on the wrong channel", x.idx);
      end
      if (is_write) begin
        check_value("b_resp", x.txn.resp, rsp.b_resp, x.idx);
      end else begin
        check_value("r_resp", x.txn.resp, rsp.r_resp, x.idx);
        check_value("r_data", x.txn.rdata, rsp.r_data, x.idx);
      end
      // response transfers at the coming edge
      if (latency_mode) check_value("latency", 32'd3, cyc + 1 - x.acc_edge, x.idx);
    end else begin
      n_fail++;
      test_fail++;
      $display("a response arrived with no transaction outstanding");
    end
  endtask

  // ##########################################################################
  // monitor, sampled mid-cycle
  // ##########################################################################
  always @(negedge clk) begin : monitor
    expect_t x;
    if (!rst) begin
      if (rsp.b_valid && req.b_ready) retire(1'b1);
      if (rsp.r_valid && req.r_ready) retire(1'b0);
      if ((req.aw_valid && rsp.aw_ready && req.w_valid && rsp.w_ready) ||
          (req.ar_valid && rsp.ar_ready)) begin
        x.txn      = cur;
        x.idx      = cur_idx;
        x.acc_edge = cyc + 1;
        exp_q.push_back(x);
        accepted = 1'b1;
      end
    end
  end

  // ##########################################################################
  // stimulus
  // ##########################################################################
  initial begin : stimulus
    int checks_before;
    lfsr         = 32'h69263d8f;
    rst          = 1'b1;
    req          = '0;
    cur          = '0;
    cur_idx      = '0;
    accepted     = 1'b0;
    latency_mode = 1'b0;
    n_pass       = 0;
    n_fail       = 0;
    test_fail    = 0;
    load_trace();
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int t = 1; t <= 6; t++) begin
      test_fail     = 0;
      checks_before = n_pass + n_fail;
      latency_mode  = (t == 5);
      for (int i = 0; i < trace_q.size(); i++) begin
        if (trace_q[i].test == t) issue(trace_q[i], i[15:0]);
      end
      idle_bus();
      while (exp_q.size() != 0) next_cycle();
      $display("test %0d %s: %0d checks, %s", t, test_name(t),
               n_pass + n_fail - checks_before, (test_fail == 0) ? "ok" : "errors");
    end
    next_cycle();
    $display("checks passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // generous per-transaction budget
  initial begin : watchdog
    wait (loaded);
    repeat (trace_q.size() * 20 + 100) @(posedge clk);
    $display("timeout, the bridge stopped answering before the trace was done");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: tb/periph_cfg_bridge_props.sv
// Handshake properties for the bridge pipeline
// bound into the capture and response stages
module periph_cfg_bridge_props (
  input logic       clk_i,
  input logic       rst_i,
  input logic [1:0] hold_valid_i,  // {b, r}
  input logic [1:0] hold_ready_i,
  input logic       aw_ready_i,
  input logic       w_ready_i,
  input logic       any_valid_i
);

  // a response stays up until the master takes it
  b_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    hold_valid_i[1] && !hold_ready_i[1] |=> hold_valid_i[1])
    else $error("b_valid dropped before b_ready");

  r_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    hold_valid_i[0] && !hold_ready_i[0] |=> hold_valid_i[0])
    else $error("r_valid dropped before r_ready");

  aw_w_pair: assert property (@(posedge clk_i) disable iff (rst_i)
    aw_ready_i == w_ready_i)
    else $error("aw_ready and w_ready differ");

  reset_clear: assert property (@(posedge clk_i) rst_i |=> !any_valid_i)
    else $error("valid high in the cycle after reset");

endmodule

bind axi_lite_respond periph_cfg_bridge_props i_respond_props (
  .clk_i        ( clk_i ),
  .rst_i        ( rst_i ),
  .hold_valid_i ( {b_valid_o, r_valid_o} ),
  .hold_ready_i ( {axi_req_i.b_ready, axi_req_i.r_ready} ),
  .aw_ready_i   ( 1'b0 ),
  .w_ready_i    ( 1'b0 ),
  .any_valid_i  ( b_valid_o || r_valid_o )
);

bind axi_lite_capture periph_cfg_bridge_props i_capture_props (
  .clk_i        ( clk_i ),
  .rst_i        ( rst_i ),
  .hold_valid_i ( 2'b00 ),
  .hold_ready_i ( 2'b00 ),
  .aw_ready_i   ( aw_ready_o ),
  .w_ready_i    ( w_ready_o ),
  .any_valid_i  ( cap_req_o.valid )
);

// File: tb/tb_clock.sv
// Testbench clock source
// free-running clock with a 40 time unit period
module tb_clock (
  output logic clk_o
);

  localparam int HalfPeriod = 20;

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

endmodule

// File: rtl/periph_cfg_bridge.sv
// Peripheral configuration bridge top level
// AXI-Lite slave -> capture, decode, respond pipeline with boot ROM and FLL banks
module periph_cfg_bridge
  import axi_lite_pkg::*;
  import regbus_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_i,
  input  axi_lite_req_t axi_lite_req_i,
  output axi_lite_rsp_t axi_lite_rsp_o
);

  reg_req_t             cap_req;
  reg_dec_t             dec_req;
  logic                 advance;
  logic                 aw_ready, w_ready, ar_ready;
  logic                 b_valid, r_valid;
  logic [1:0]           b_resp, r_resp;
  logic [DataWidth-1:0] r_data;

  logic     dec_ok;
  logic     sel_fll_system, sel_fll_periph, sel_fll_hbm2e;
  reg_rsp_t bootrom_rsp, fll_system_rsp, fll_periph_rsp, fll_hbm2e_rsp;
  reg_rsp_t tgt_rsp;

  axi_lite_capture i_capture (
    .clk_i,
    .rst_i,
    .axi_req_i  ( axi_lite_req_i ),
    .advance_i  ( advance ),
    .aw_ready_o ( aw_ready ),
    .w_ready_o  ( w_ready ),
    .ar_ready_o ( ar_ready ),
    .cap_req_o  ( cap_req )
  );

  reg_addr_decode i_decode (
    .clk_i,
    .rst_i,
    .cap_req_i ( cap_req ),
    .advance_i ( advance ),
    .dec_req_o ( dec_req )
  );

  // ##########################################################################
  // targets
  // ##########################################################################
  assign dec_ok         = dec_req.req.valid && !dec_req.err;  // illegal ops never write
  assign sel_fll_system = dec_ok && (dec_req.target == tgt_fll_system);
  assign sel_fll_periph = dec_ok && (dec_req.target == tgt_fll_periph);
  assign sel_fll_hbm2e  = dec_ok && (dec_req.target == tgt_fll_hbm2e);

  bootrom_rom i_bootrom (
    .req_i ( dec_req.req ),
    .rsp_o ( bootrom_rsp )
  );

  fll_cfg_regs i_fll_system (
    .clk_i, .rst_i,
    .sel_i ( sel_fll_system ), .advance_i ( advance ),
    .req_i ( dec_req.req ),    .rsp_o     ( fll_system_rsp )
  );

  fll_cfg_regs i_fll_periph (
    .clk_i, .rst_i,
    .sel_i ( sel_fll_periph ), .advance_i ( advance ),
    .req_i ( dec_req.req ),    .rsp_o     ( fll_periph_rsp )
  );

  fll_cfg_regs i_fll_hbm2e (
    .clk_i, .rst_i,
    .sel_i ( sel_fll_hbm2e ), .advance_i ( advance ),
    .req_i ( dec_req.req ),   .rsp_o     ( fll_hbm2e_rsp )
  );

  always_comb begin
    case (dec_req.target)
      tgt_bootrom:    tgt_rsp = bootrom_rsp;
      tgt_fll_system: tgt_rsp = fll_system_rsp;
      tgt_fll_periph: tgt_rsp = fll_periph_rsp;
      tgt_fll_hbm2e:  tgt_rsp = fll_hbm2e_rsp;
      default:        tgt_rsp = '{rdata: '0, err: 1'b1};  // unmapped
    endcase
  end

  axi_lite_respond i_respond (
    .clk_i,
    .rst_i,
    .dec_req_i ( dec_req ),
    .tgt_rsp_i ( tgt_rsp ),
    .axi_req_i ( axi_lite_req_i ),
    .b_valid_o ( b_valid ),
    .b_resp_o  ( b_resp ),
    .r_valid_o ( r_valid ),
    .r_data_o  ( r_data ),
    .r_resp_o  ( r_resp ),
    .advance_o ( advance )
  );

  always_comb begin
    axi_lite_rsp_o.aw_ready = aw_ready;
    axi_lite_rsp_o.w_ready  = w_ready;
    axi_lite_rsp_o.b_valid  = b_valid;
    axi_lite_rsp_o.b_resp   = b_resp;
    axi_lite_rsp_o.ar_ready = ar_ready;
    axi_lite_rsp_o.r_valid  = r_valid;
    axi_lite_rsp_o.r_data   = r_data;
    axi_lite_rsp_o.r_resp   = r_resp;
  end

endmodule

// File: rtl/axi_lite_respond.sv
// AXI-Lite response stage
// one-entry buffer routing each target response to the B or R channel
module axi_lite_respond
  import axi_lite_pkg::*;
  import regbus_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  reg_dec_t             dec_req_i,
  input  reg_rsp_t             tgt_rsp_i,
  input  axi_lite_req_t        axi_req_i,
  output logic                 b_valid_o,
  output logic [1:0]           b_resp_o,
  output logic                 r_valid_o,
  output logic [DataWidth-1:0] r_data_o,
  output logic [1:0]           r_resp_o,
  output logic                 advance_o
);

  typedef struct packed {
    logic                 valid;
    reg_op_e              op;
    logic [1:0]           resp;
    logic [DataWidth-1:0] data;
  } rsp_buf_t;

  rsp_buf_t rsp_q;
  logic     drain;
  logic     rsp_err;

  // ##########################################################################
  // stall control
  // ##########################################################################
  assign drain = rsp_q.valid &&
                 ((rsp_q.op == op_write) ? axi_req_i.b_ready : axi_req_i.r_ready);

  // whole pipeline moves only when this entry is free
  assign advance_o = !rsp_q.valid || drain;

  assign rsp_err = dec_req_i.err || tgt_rsp_i.err;

  // ##########################################################################
  // response buffer
  // ##########################################################################
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_q.valid <= 1'b0;
    end else if (advance_o) begin
      rsp_q.valid <= dec_req_i.req.valid;
      rsp_q.op    <= dec_req_i.req.op;
      rsp_q.resp  <= rsp_err ? RespSlvErr : RespOkay;
      rsp_q.data  <= (rsp_err || dec_req_i.req.op == op_write) ? '0 : tgt_rsp_i.rdata;
    end
  end

  assign b_valid_o = rsp_q.valid && (rsp_q.op == op_write);
  assign b_resp_o  = rsp_q.resp;
  assign r_valid_o = rsp_q.valid && (rsp_q.op == op_read);
  assign r_data_o  = rsp_q.data;
  assign r_resp_o  = rsp_q.resp;

endmodule

// File: rtl/bootrom_rom.sv
// Boot ROM
// fixed 16-word boot table, combinational read
module bootrom_rom
  import axi_lite_pkg::*;
  import regbus_pkg::*;
(
  input  reg_req_t req_i,
  output reg_rsp_t rsp_o
);

  localparam logic [DataWidth-1:0] BootTable [BootromWords] = '{
    32'hf140_2573,  // csrr a0, mhartid
    32'h0000_0597,
    32'h03c5_8593,
    32'h0005_1463,  // hart 0 only
    32'h0080_006f,
    32'h1050_0073,  // wfi
    32'hffdf_f06f,
    32'h0200_02b7,
    32'h0012_8293,
    32'h0052_a023,
    32'h0100_0337,
    32'h0403_0313,
    32'h0003_0067,
    32'h0000_0013,
    32'h0000_0013,
    32'hb007_c0de   // table tag
  };

  assign rsp_o.rdata = BootTable[req_i.addr[5:2]];
  assign rsp_o.err   = (req_i.op == op_write);  // no write path

endmodule

// File: rtl/fll_cfg_regs.sv
// FLL configuration bank
// three byte-writable config words and a read-only lock status word
module fll_cfg_regs
  import axi_lite_pkg::*;
  import regbus_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     sel_i,
  input  logic     advance_i,
  input  reg_req_t req_i,
  output reg_rsp_t rsp_o
);

  // word 0 bit 0 is the loop enable
  logic [DataWidth-1:0] cfg_q [FllLockReg];

  logic [1:0] idx;
  logic       is_lock;
  logic       wr_en;

  assign idx     = req_i.addr[3:2];
  assign is_lock = (idx == 2'(FllLockReg));

  // only on an advancing cycle, so a stalled write lands once
  assign wr_en = sel_i && advance_i && (req_i.op == op_write) && !is_lock;

  // ##########################################################################
  // config words
  // ##########################################################################
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int w = 0; w < FllLockReg; w++) begin
        cfg_q[w] <= '0;
      end
    end else if (wr_en) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (req_i.wstrb[b]) cfg_q[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
      end
    end
  end

  // ##########################################################################
  // read path
  // ##########################################################################
  always_comb begin
    rsp_o.err = 1'b0;
    if (is_lock) begin
      // locks as soon as it is enabled
      rsp_o.rdata = {{(DataWidth-1){1'b0}}, cfg_q[0][0]};
    end else begin
      rsp_o.rdata = cfg_q[idx];
    end
  end

endmodule

// File: rtl/reg_addr_decode.sv
// Register address decode stage
// tags each request with its target and flags unmapped or illegal accesses
module reg_addr_decode
  import axi_lite_pkg::*;
  import regbus_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  reg_req_t cap_req_i,
  input  logic     advance_i,
  output reg_dec_t dec_req_o
);

  function automatic logic in_range(logic [AddrWidth-1:0] addr,
                                    logic [AddrWidth-1:0] base,
                                    int unsigned          size);
    return (addr >= base) && (addr < base + AddrWidth'(size));
  endfunction

  reg_target_e target;
  logic        is_write;
  logic        lock_hit;
  logic        is_fll;
  logic        err;
  reg_dec_t    dec_q;

  always_comb begin
    target = tgt_none;
    if (in_range(cap_req_i.addr, BootromBase, BootromSize)) target = tgt_bootrom;
    else if (in_range(cap_req_i.addr, FllSystemBase, FllSize)) target = tgt_fll_system;
    else if (in_range(cap_req_i.addr, FllPeriphBase, FllSize)) target = tgt_fll_periph;
    else if (in_range(cap_req_i.addr, FllHbm2eBase, FllSize)) target = tgt_fll_hbm2e;
  end

  assign is_write = (cap_req_i.op == op_write);
  assign is_fll   = (target inside {tgt_fll_system, tgt_fll_periph, tgt_fll_hbm2e});
  assign lock_hit = is_fll && (cap_req_i.addr[3:2] == 2'(FllLockReg));

  // rom and lock status are read-only
  assign err = (target == tgt_none) ||
               (is_write && target == tgt_bootrom) ||
               (is_write && lock_hit);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dec_q.req.valid <= 1'b0;
    end else if (advance_i) begin
      dec_q.req    <= cap_req_i;
      dec_q.target <= target;
      dec_q.err    <= err;
    end
  end

  assign dec_req_o = dec_q;

endmodule

// File: rtl/axi_lite_capture.sv
// AXI-Lite capture stage
// accepts one write (AW+W) or one read (AR) per cycle into a request register
module axi_lite_capture
  import axi_lite_pkg::*;
  import regbus_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_i,
  input  axi_lite_req_t axi_req_i,
  input  logic          advance_i,
  output logic          aw_ready_o,
  output logic          w_ready_o,
  output logic          ar_ready_o,
  output reg_req_t      cap_req_o
);

  reg_req_t cap_q;
  logic     last_wr_q;  // last grant went to the write side

  logic wr_pending;
  logic rd_pending;
  logic can_load;
  logic grant_wr;
  logic grant_rd;

  // ##########################################################################
  // arbitration
  // ##########################################################################
  assign wr_pending = axi_req_i.aw_valid && axi_req_i.w_valid;
  assign rd_pending = axi_req_i.ar_valid;
  assign can_load   = !cap_q.valid || advance_i;

  // alternate on contention, write wins first after reset
  assign grant_wr = can_load && wr_pending && (!rd_pending || !last_wr_q);
  assign grant_rd = can_load && rd_pending && (!wr_pending || last_wr_q);

  assign aw_ready_o = grant_wr;
  assign w_ready_o  = grant_wr;  // always paired with aw_ready
  assign ar_ready_o = grant_rd;

  // ##########################################################################
  // request register
  // ##########################################################################
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cap_q.valid <= 1'b0;
      last_wr_q   <= 1'b0;
    end else if (can_load) begin
      cap_q.valid <= grant_wr || grant_rd;
      if (grant_wr) begin
        cap_q.op    <= op_write;
        cap_q.addr  <= axi_req_i.aw_addr;
        cap_q.wdata <= axi_req_i.w_data;
        cap_q.wstrb <= axi_req_i.w_strb;
        last_wr_q   <= 1'b1;
      end else if (grant_rd) begin
        cap_q.op    <= op_read;
        cap_q.addr  <= axi_req_i.ar_addr;
        cap_q.wdata <= '0;
        cap_q.wstrb <= '0;
        last_wr_q   <= 1'b0;
      end
    end
  end

  assign cap_req_o = cap_q;

endmodule

// File: rtl/regbus_pkg.sv
// Register bus types and address map of the configuration targets
// boot ROM plus three FLL configuration banks
package regbus_pkg;

  import axi_lite_pkg::*;

  typedef enum logic {
    op_read,
    op_write
  } reg_op_e;

  typedef enum logic [2:0] {
    tgt_bootrom,
    tgt_fll_system,
    tgt_fll_periph,
    tgt_fll_hbm2e,
    tgt_none
  } reg_target_e;

  // address map, sizes in bytes
  localparam logic [AddrWidth-1:0] BootromBase   = 48'h0000_0100_0000;
  localparam int unsigned          BootromSize   = 64;
  localparam int unsigned          BootromWords  = BootromSize / 4;
  localparam logic [AddrWidth-1:0] FllSystemBase = 48'h0000_0200_0000;
  localparam logic [AddrWidth-1:0] FllPeriphBase = 48'h0000_0200_1000;
  localparam logic [AddrWidth-1:0] FllHbm2eBase  = 48'h0000_0200_2000;
  localparam int unsigned          FllSize       = 16;
  localparam int unsigned          FllLockReg    = 3;  // read-only word

  typedef struct packed {
    logic                 valid;
    reg_op_e              op;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] wstrb;
  } reg_req_t;

  typedef struct packed {
    reg_req_t    req;
    reg_target_e target;
    logic        err;
  } reg_dec_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } reg_rsp_t;

endpackage

// File: rtl/axi_lite_pkg.sv
// AXI-Lite channel types for the peripheral configuration bridge
// 48-bit address, 32-bit data, single outstanding beat per channel
package axi_lite_pkg;

  localparam int unsigned AddrWidth = 48;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // B and R response codes
  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

  // ##########################################################################
  // master to slave
  // ##########################################################################
  typedef struct packed {
    logic                 aw_valid;
    logic [AddrWidth-1:0] aw_addr;
    logic                 w_valid;
    logic [DataWidth-1:0] w_data;
    logic [StrbWidth-1:0] w_strb;
    logic                 b_ready;
    logic                 ar_valid;
    logic [AddrWidth-1:0] ar_addr;
    logic                 r_ready;
  } axi_lite_req_t;

  // ##########################################################################
  // slave to master
  // ##########################################################################
  typedef struct packed {
    logic                 aw_ready;
    logic                 w_ready;
    logic                 b_valid;
    logic [1:0]           b_resp;
    logic                 ar_ready;
    logic                 r_valid;
    logic [DataWidth-1:0] r_data;
    logic [1:0]           r_resp;
  } axi_lite_rsp_t;

endpackage
